// File: all.f
common/sld_pkg.sv
src/sld_issue.sv
sld_datapath/sld_operand.sv
sld_datapath/sld_shifter.sv
src/sld_writeback.sv
src/vproc_sld_top.sv
testbench/sld_sva.sv
testbench/tb_sld.sv

// File: common/sld_pkg.sv
//////////////////////////////
// shared widths, encodings and packed structs of the slide unit
// imported by every RTL module and by the testbench
//////////////////////////////

package sld_pkg;

    // vector register geometry
    localparam int unsigned VREG_W     = 128;
    localparam int unsigned VMSK_W     = VREG_W / 8;
    localparam int unsigned BYTE_IDX_W = $clog2(VMSK_W);

    // datapath slices
    localparam int unsigned SLD_OP_W = 32;
    localparam int unsigned OP_BYTES = SLD_OP_W / 8;
    localparam int unsigned SLICES   = VREG_W / SLD_OP_W;
    localparam int unsigned SHIFT_W  = $clog2(OP_BYTES);

    // vl holds up to 16 elements, the counter also covers the drain cycles
    localparam int unsigned VL_W  = 5;
    localparam int unsigned CNT_W = 3;

    // cycles from the acknowledge to the register write
    localparam int unsigned SLD_LATENCY = 8;

    typedef enum logic {
        SLD_UP   = 1'b0,
        SLD_DOWN = 1'b1
    } sld_mode_e;

    // encoding equals log2 of the element size in bytes
    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } sld_eew_e;

    typedef struct packed {
        sld_mode_e       mode;
        logic            masked;
        sld_eew_e        eew;
        logic [VL_W-1:0] vl;
        logic [31:0]     rs1;
        logic [4:0]      vs2;
        logic [4:0]      vd;
    } sld_op_t;

    typedef struct packed {
        logic [CNT_W-1:0]   count;
        logic               first;
        logic               last;
        logic [SHIFT_W-1:0] op_shift;
        logic [CNT_W-1:0]   store_idx;
        logic               store_valid;
        sld_mode_e          mode;
        logic               masked;
        sld_eew_e           eew;
        logic [VL_W-1:0]    vl;
        logic [4:0]         vd;
        // slide amount in bytes, saturated at VREG_W/8
        logic [7:0]         offset;
    } sld_ctrl_t;

    typedef struct packed {
        logic              en;
        logic [4:0]        addr;
        logic [VREG_W-1:0] data;
        logic [VMSK_W-1:0] mask;
    } vreg_wr_t;

endpackage

// File: run.sh
#!/bin/sh
# build the slide unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_sld -f all.f --Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_sld > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" sim.log; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0

// File: sld_datapath/sld_operand.sv
//////////////////////////////
// source operand stage, feeds the shifter with two adjacent slices
//////////////////////////////

`timescale 1ns/1ps

module sld_operand import sld_pkg::*; (
    input  logic                clk_i,
    input  logic                async_rst_ni,
    input  sld_ctrl_t           ctrl_i,
    input  logic [VREG_W-1:0]   vreg_rd_i,
    output sld_ctrl_t           ctrl_o,
    output logic [SLD_OP_W-1:0] op_low_o,
    output logic [SLD_OP_W-1:0] op_high_o
);

    sld_ctrl_t           ctrl_q;
    logic [VREG_W-1:0]   shift_q;
    logic [SLD_OP_W-1:0] spill_q;
    logic [VREG_W-1:0]   load_val;
    logic [7:0]          src_idx;

    // slide-down starts reading at the whole-slice part of the offset
    always_comb begin
        load_val = vreg_rd_i;
        if (ctrl_i.mode == SLD_DOWN) begin
            load_val = vreg_rd_i >> ((ctrl_i.offset >> SHIFT_W) * SLD_OP_W);
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= ctrl_i;
        end
    end

    // source register is read once, then drained one slice per cycle
    always_ff @(posedge clk_i) begin
        if (ctrl_i.first) begin
            shift_q <= load_val;
        end else begin
            shift_q <= shift_q >> SLD_OP_W;
        end
        spill_q <= op_high_o;
    end

    // index of the source slice presented as the high operand
    assign src_idx = 8'(ctrl_q.count) + (ctrl_q.offset >> SHIFT_W);

    always_comb begin
        op_high_o = shift_q[SLD_OP_W-1:0];
        // elements past VLMAX read as zero for slide-down
        if (ctrl_q.mode == SLD_DOWN && src_idx >= 8'(SLICES)) begin
            op_high_o = '0;
        end
    end

    assign op_low_o = spill_q;
    assign ctrl_o   = ctrl_q;

endmodule

// File: sld_datapath/sld_shifter.sv
//////////////////////////////
// byte-window shifter, builds one result slice per cycle
//////////////////////////////

`timescale 1ns/1ps

module sld_shifter import sld_pkg::*; (
    input  logic                clk_i,
    input  logic                async_rst_ni,
    input  sld_ctrl_t           ctrl_i,
    input  logic [SLD_OP_W-1:0] op_low_i,
    input  logic [SLD_OP_W-1:0] op_high_i,
    output sld_ctrl_t           ctrl_o,
    output logic [SLD_OP_W-1:0] result_o,
    output logic [OP_BYTES-1:0] result_valid_o
);

    sld_ctrl_t           ctrl_q;
    logic [SLD_OP_W-1:0] result_q;
    logic [SLD_OP_W-1:0] result_d;
    logic [OP_BYTES-1:0] valid_q;
    logic [OP_BYTES-1:0] valid_d;
    logic [SHIFT_W:0]    sel;

    // window over {high, low} starting at byte op_shift
    always_comb begin
        result_d = '0;
        valid_d  = '0;
        sel      = '0;
        for (int i = 0; i < OP_BYTES; i++) begin
            sel = (SHIFT_W + 1)'(ctrl_i.op_shift) + (SHIFT_W + 1)'(i);
            if (sel < OP_BYTES) begin
                result_d[i*8 +: 8] = op_low_i[sel*8 +: 8];
                // nothing precedes the first slice, these bytes sit below the offset
                valid_d[i] = ~ctrl_i.first;
            end else begin
                result_d[i*8 +: 8] = op_high_i[(sel - OP_BYTES)*8 +: 8];
                // zeros past the end are real results of a slide-down
                valid_d[i] = ~(ctrl_i.last && ctrl_i.mode == SLD_UP);
            end
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            ctrl_q  <= '0;
            valid_q <= '0;
        end else begin
            ctrl_q  <= ctrl_i;
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        result_q <= result_d;
    end

    assign ctrl_o         = ctrl_q;
    assign result_o       = result_q;
    assign result_valid_o = valid_q;

endmodule

// File: src/sld_issue.sv
//////////////////////////////
// instruction intake of the slide unit
// decodes the slide amount and sequences one slice per cycle
//////////////////////////////

`timescale 1ns/1ps

module sld_issue import sld_pkg::*; (
    input  logic       clk_i,
    input  logic       async_rst_ni,
    input  logic       op_rdy_i,
    input  sld_op_t    op_i,
    output logic       op_ack_o,
    output logic [4:0] vreg_rd_addr_o,
    output sld_ctrl_t  ctrl_o
);

    logic               active_q;
    logic [CNT_W-1:0]   count_q;
    logic [CNT_W-1:0]   store_idx_q;
    sld_op_t            op_q;
    logic [SHIFT_W-1:0] op_shift_q;
    logic [7:0]         offset_q;

    logic [33:0]        byte_off_full;
    logic [7:0]         byte_off;
    logic [7:0]         up_slices;
    logic [CNT_W-1:0]   store_start;
    logic [SHIFT_W-1:0] shift_start;
    logic               busy;

    //////////////////////////////
    // slide amount decode

    always_comb begin
        byte_off_full = 34'(op_i.rs1) << op_i.eew;
        // anything at or past the register end behaves like a full register
        if (byte_off_full >= 34'(VREG_W / 8)) begin
            byte_off = 8'(VREG_W / 8);
        end else begin
            byte_off = byte_off_full[7:0];
        end
        // destination slices touched before the first full source slice
        up_slices = (byte_off + 8'(OP_BYTES - 1)) >> SHIFT_W;
        if (op_i.mode == SLD_UP) begin
            store_start = CNT_W'(up_slices - 8'd1);
            shift_start = -byte_off[SHIFT_W-1:0];
        end else begin
            // first slice of a slide-down only primes the low operand
            store_start = '1;
            shift_start = byte_off[SHIFT_W-1:0];
        end
    end

    //////////////////////////////
    // sequencing

    assign busy           = active_q && (count_q <= CNT_W'(SLICES));
    assign op_ack_o       = ~active_q & op_rdy_i;
    assign vreg_rd_addr_o = op_q.vs2;

    // stays active until the write leaves the last stage
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            active_q    <= 1'b0;
            count_q     <= '0;
            store_idx_q <= '0;
        end else if (op_ack_o) begin
            active_q    <= 1'b1;
            count_q     <= '0;
            store_idx_q <= store_start;
        end else if (active_q) begin
            count_q     <= count_q + 1'b1;
            store_idx_q <= store_idx_q + 1'b1;
            if (count_q == CNT_W'(SLD_LATENCY - 1)) begin
                active_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (op_ack_o) begin
            op_q       <= op_i;
            op_shift_q <= shift_start;
            offset_q   <= byte_off;
        end
    end

    always_comb begin
        ctrl_o.count       = count_q;
        ctrl_o.first       = busy && (count_q == '0);
        ctrl_o.last        = busy && (count_q == CNT_W'(SLICES));
        ctrl_o.op_shift    = op_shift_q;
        ctrl_o.store_idx   = store_idx_q;
        ctrl_o.store_valid = busy && (store_idx_q < CNT_W'(SLICES));
        ctrl_o.mode        = op_q.mode;
        ctrl_o.masked      = op_q.masked;
        ctrl_o.eew         = op_q.eew;
        ctrl_o.vl          = op_q.vl;
        ctrl_o.vd          = op_q.vd;
        ctrl_o.offset      = offset_q;
    end

endmodule

// File: src/sld_writeback.sv
//////////////////////////////
// result assembly and masking, issues one write per instruction
//////////////////////////////

`timescale 1ns/1ps

module sld_writeback import sld_pkg::*; (
    input  logic                clk_i,
    input  logic                async_rst_ni,
    input  sld_ctrl_t           ctrl_i,
    input  logic [SLD_OP_W-1:0] result_i,
    input  logic [OP_BYTES-1:0] result_valid_i,
    input  logic [VREG_W-1:0]   vreg_mask_i,
    output vreg_wr_t            vreg_wr_o
);

    logic [VREG_W-1:0]     data_q;
    logic [VMSK_W-1:0]     mask_q;
    logic [VMSK_W-1:0]     v0_q;
    logic [4:0]            vd_q;
    logic                  wr_en_q;

    logic [VMSK_W-1:0]     v0_src;
    logic [7:0]            vl_bytes;
    logic [BYTE_IDX_W-1:0] byte_idx;
    logic [OP_BYTES-1:0]   tail_bytes;
    logic [OP_BYTES-1:0]   v0_bytes;
    logic [OP_BYTES-1:0]   slice_mask;

    //////////////////////////////
    // per-slice byte enables

    always_comb begin
        // v0 only holds one bit per element, up to VMSK_W elements
        v0_src   = ctrl_i.first ? vreg_mask_i[VMSK_W-1:0] : v0_q;
        vl_bytes = 8'(ctrl_i.vl) << ctrl_i.eew;
        byte_idx = '0;
        for (int i = 0; i < OP_BYTES; i++) begin
            byte_idx      = BYTE_IDX_W'(ctrl_i.store_idx * OP_BYTES + i);
            tail_bytes[i] = 8'(byte_idx) < vl_bytes;
            // element mask bit repeated across the bytes of the element
            v0_bytes[i]   = ~ctrl_i.masked | v0_src[byte_idx >> ctrl_i.eew];
        end
        slice_mask = result_valid_i & tail_bytes & v0_bytes
                   & {OP_BYTES{ctrl_i.store_valid}};
    end

    //////////////////////////////
    // result register and write

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            mask_q  <= '0;
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= ctrl_i.last;
            if (ctrl_i.first) begin
                mask_q <= '0;
            end
            // a later slice write overrides the clear for its own bytes
            if (ctrl_i.store_valid) begin
                mask_q[ctrl_i.store_idx*OP_BYTES +: OP_BYTES] <= slice_mask;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctrl_i.first) begin
            v0_q <= vreg_mask_i[VMSK_W-1:0];
        end
        if (ctrl_i.store_valid) begin
            data_q[ctrl_i.store_idx*SLD_OP_W +: SLD_OP_W] <= result_i;
        end
        if (ctrl_i.last) begin
            vd_q <= ctrl_i.vd;
        end
    end

    always_comb begin
        vreg_wr_o.en   = wr_en_q;
        vreg_wr_o.addr = vd_q;
        vreg_wr_o.data = data_q;
        vreg_wr_o.mask = wr_en_q ? mask_q : '0;
    end

endmodule

// File: src/vproc_sld_top.sv
//////////////////////////////
// slide unit top level
// issue, operand, shifter and writeback stages in a row
//////////////////////////////

`timescale 1ns/1ps

module vproc_sld_top import sld_pkg::*; (
    input  logic              clk_i,
    input  logic              async_rst_ni,

    // instruction in
    input  logic              op_rdy_i,
    input  sld_op_t           op_i,
    output logic              op_ack_o,

    // register file
    output logic [4:0]        vreg_rd_addr_o,
    input  logic [VREG_W-1:0] vreg_rd_i,
    input  logic [VREG_W-1:0] vreg_mask_i,
    output vreg_wr_t          vreg_wr_o
);

    sld_ctrl_t           ctrl_issue;
    sld_ctrl_t           ctrl_operand;
    sld_ctrl_t           ctrl_shifter;
    logic [SLD_OP_W-1:0] op_low;
    logic [SLD_OP_W-1:0] op_high;
    logic [SLD_OP_W-1:0] result;
    logic [OP_BYTES-1:0] result_valid;

    sld_issue i_issue (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .op_rdy_i       (op_rdy_i),
        .op_i           (op_i),
        .op_ack_o       (op_ack_o),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .ctrl_o         (ctrl_issue)
    );

    sld_operand i_operand (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .ctrl_i       (ctrl_issue),
        .vreg_rd_i    (vreg_rd_i),
        .ctrl_o       (ctrl_operand),
        .op_low_o     (op_low),
        .op_high_o    (op_high)
    );

    sld_shifter i_shifter (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .ctrl_i         (ctrl_operand),
        .op_low_i       (op_low),
        .op_high_i      (op_high),
        .ctrl_o         (ctrl_shifter),
        .result_o       (result),
        .result_valid_o (result_valid)
    );

    sld_writeback i_writeback (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .ctrl_i         (ctrl_shifter),
        .result_i       (result),
        .result_valid_i (result_valid),
        .vreg_mask_i    (vreg_mask_i),
        .vreg_wr_o      (vreg_wr_o)
    );

endmodule

// File: testbench/sld_sva.sv
//////////////////////////////
// protocol assertions of the slide unit, bound to the top level
//////////////////////////////

`timescale 1ns/1ps

module sld_sva import sld_pkg::*; (
    input  logic     clk_i,
    input  logic     async_rst_ni,
    input  logic     op_ack_i,
    input  sld_op_t  op_i,
    input  vreg_wr_t vreg_wr_i
);

    logic [3:0]        busy_cnt_q;
    logic [7:0]        vl_bytes_q;
    logic [VMSK_W-1:0] vl_mask;

    // cycles left until the write of the accepted instruction
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            busy_cnt_q <= '0;
            vl_bytes_q <= '0;
        end else if (op_ack_i) begin
            busy_cnt_q <= 4'(SLD_LATENCY);
            vl_bytes_q <= 8'(op_i.vl) << op_i.eew;
        end else if (busy_cnt_q != '0) begin
            busy_cnt_q <= busy_cnt_q - 4'd1;
        end
    end

    always_comb begin
        for (int b = 0; b < VMSK_W; b++) begin
            vl_mask[b] = 8'(b) < vl_bytes_q;
        end
    end

    ack_low_while_busy: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        busy_cnt_q != '0 |-> !op_ack_i)
        else $error("acknowledge raised while an instruction is in flight");

    write_single_pulse: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        vreg_wr_i.en |=> !vreg_wr_i.en)
        else $error("write enable held for more than one cycle");

    write_at_latency: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        vreg_wr_i.en == (busy_cnt_q == 4'd1))
        else $error("write enable not at the expected cycle after the acknowledge");

    mask_inside_vl: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        vreg_wr_i.en |-> (vreg_wr_i.mask & ~vl_mask) == '0)
        else $error("write mask has bytes set at or beyond vl");

endmodule

bind vproc_sld_top sld_sva i_sva (
    .clk_i        (clk_i),
    .async_rst_ni (async_rst_ni),
    .op_ack_i     (op_ack_o),
    .op_i         (op_i),
    .vreg_wr_i    (vreg_wr_o)
);

// File: testbench/tb_sld.sv
//////////////////////////////
// testbench of the slide unit with a register file model
// random slide instructions are checked against the slide rules
//////////////////////////////

`timescale 1ns/1ps

module tb_sld import sld_pkg::*; ();

    logic              clk_i;
    logic              async_rst_ni;
    logic              op_rdy;
    sld_op_t           op;
    logic              op_ack;
    logic [4:0]        rd_addr;
    logic [VREG_W-1:0] rd_data;
    logic [VREG_W-1:0] v0_data;
    vreg_wr_t          wr;

    logic [VREG_W-1:0] rf [32];
    integer            seed;
    int                errors;
    int                checks;
    int unsigned       wr_count;
    bit                timed_out;

    vproc_sld_top i_dut (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .op_rdy_i       (op_rdy),
        .op_i           (op),
        .op_ack_o       (op_ack),
        .vreg_rd_addr_o (rd_addr),
        .vreg_rd_i      (rd_data),
        .vreg_mask_i    (v0_data),
        .vreg_wr_o      (wr)
    );

    // register file read port and v0 answer combinationally
    assign rd_data = rf[rd_addr];
    assign v0_data = rf[0];

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    always @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            wr_count <= 0;
        end else if (wr.en) begin
            wr_count <= wr_count + 1;
        end
    end

    //////////////////////////////
    // helpers

    task automatic random_vreg(output logic [VREG_W-1:0] v);
        for (int k = 0; k < VREG_W / 32; k++) begin
            v[k*32 +: 32] = $random(seed);
        end
    endtask

    task automatic check_equal(input string what, input logic [VREG_W-1:0] expected,
                               input logic [VREG_W-1:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("mismatch %s: expected %0h, actual %0h", what, expected, actual);
        end
    endtask

    // destination after the slide where inactive and tail elements keep old data
    function automatic logic [VREG_W-1:0] slide_model(sld_op_t o, logic [VREG_W-1:0] src,
                                                       logic [VREG_W-1:0] v0,
                                                       logic [VREG_W-1:0] old);
        logic [VREG_W-1:0] res;
        int                esize;
        int                vlmax;
        longint unsigned   idx;
        res   = old;
        esize = 1 << int'(o.eew);
        vlmax = int'(VMSK_W) / esize;
        for (int i = 0; i < vlmax; i++) begin
            if (i < int'(o.vl) && (!o.masked || v0[i])) begin
                if (o.mode == SLD_UP) begin
                    if (64'(o.rs1) <= 64'(i)) begin
                        idx = 64'(i) - 64'(o.rs1);
                        for (int b = 0; b < esize; b++) begin
                            res[(i*esize + b)*8 +: 8] = src[(int'(idx)*esize + b)*8 +: 8];
                        end
                    end
                end else begin
                    idx = 64'(i) + 64'(o.rs1);
                    for (int b = 0; b < esize; b++) begin
                        if (idx < 64'(vlmax)) begin
                            res[(i*esize + b)*8 +: 8] = src[(int'(idx)*esize + b)*8 +: 8];
                        end else begin
                            res[(i*esize + b)*8 +: 8] = 8'h00;
                        end
                    end
                end
            end
        end
        return res;
    endfunction

    task automatic wait_ack(output bit ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < 4 * SLD_LATENCY) begin
            @(negedge clk_i);
            cycles++;
            ok = op_ack;
        end
        if (!ok) begin
            errors++;
            $display("timeout: no acknowledge within %0d cycles", 4 * SLD_LATENCY);
        end
    endtask

    task automatic wait_write(output bit ok, output int cycles);
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < 4 * SLD_LATENCY) begin
            @(negedge clk_i);
            cycles++;
            ok = wr.en;
        end
        if (!ok) begin
            errors++;
            $display("timeout: no register write within %0d cycles", 4 * SLD_LATENCY);
        end
    endtask

    //////////////////////////////
    // one instruction from issue to write

    task automatic run_case(input string name, input sld_mode_e mode, input sld_eew_e eew,
                            input bit masked, input bit rand_vl, input bit big_off);
        sld_op_t           o;
        logic [VREG_W-1:0] expected;
        int                vlmax;
        int                cycles;
        int unsigned       wr_before;
        bit                ok;
        if (timed_out) return;
        vlmax    = int'(VMSK_W) >> int'(eew);
        o.mode   = mode;
        o.masked = masked;
        o.eew    = eew;
        if (rand_vl) begin
            o.vl = VL_W'($unsigned($random(seed)) % (vlmax + 1));
        end else begin
            o.vl = VL_W'(vlmax);
        end
        if (!big_off) begin
            o.rs1 = $unsigned($random(seed)) % vlmax;
        end else if ($random(seed) & 1) begin
            o.rs1 = 32'(vlmax) + ($unsigned($random(seed)) % 32'd8);
        end else begin
            o.rs1 = $random(seed) | 32'h8000_0000;
        end
        // v0 stays a pure mask register
        o.vs2 = 5'd1 + 5'($unsigned($random(seed)) % 31);
        o.vd  = 5'd1 + 5'($unsigned($random(seed)) % 31);
        random_vreg(rf[o.vs2]);
        random_vreg(rf[o.vd]);
        random_vreg(rf[0]);
        expected  = slide_model(o, rf[o.vs2], rf[0], rf[o.vd]);
        wr_before = wr_count;

        @(posedge clk_i);
        op     <= o;
        op_rdy <= 1'b1;
        wait_ack(ok);
        if (!ok) begin
            timed_out = 1'b1;
            return;
        end
        // the request stays raised while the unit is busy
        wait_write(ok, cycles);
        if (!ok) begin
            timed_out = 1'b1;
            return;
        end
        check_equal({name, " latency"}, VREG_W'(SLD_LATENCY), VREG_W'(cycles));
        check_equal({name, " write address"}, VREG_W'(o.vd), VREG_W'(wr.addr));
        for (int b = 0; b < VMSK_W; b++) begin
            if (wr.mask[b]) begin
                rf[wr.addr][b*8 +: 8] = wr.data[b*8 +: 8];
            end
        end
        check_equal(name, expected, rf[o.vd]);
        @(posedge clk_i);
        op_rdy <= 1'b0;
        @(negedge clk_i);
        check_equal({name, " write count"}, VREG_W'(1), VREG_W'(wr_count - wr_before));
    endtask

    //////////////////////////////
    // test sequence

    initial begin
        sld_eew_e eew;
        seed         = 32'h36b5;
        errors       = 0;
        checks       = 0;
        timed_out    = 1'b0;
        async_rst_ni = 1'b0;
        op_rdy       = 1'b0;
        op           = '0;
        for (int r = 0; r < 32; r++) begin
            random_vreg(rf[r]);
        end
        repeat (3) @(posedge clk_i);
        async_rst_ni <= 1'b1;
        @(negedge clk_i);
        check_equal("acknowledge after reset", '0, VREG_W'(op_ack));
        check_equal("write enable after reset", '0, VREG_W'(wr.en));

        for (int e = 0; e < 3; e++) begin
            eew = sld_eew_e'(e);
            for (int n = 0; n < 4; n++) begin
                run_case($sformatf("slide_up_e%0d", 8 << e), SLD_UP, eew, 0, 0, 0);
                run_case($sformatf("slide_down_e%0d", 8 << e), SLD_DOWN, eew, 0, 0, 0);
            end
            for (int n = 0; n < 3; n++) begin
                run_case($sformatf("tail_up_e%0d", 8 << e), SLD_UP, eew, 0, 1, 0);
                run_case($sformatf("tail_down_e%0d", 8 << e), SLD_DOWN, eew, 0, 1, 0);
                run_case($sformatf("masked_up_e%0d", 8 << e), SLD_UP, eew, 1, 1, 0);
                run_case($sformatf("masked_down_e%0d", 8 << e), SLD_DOWN, eew, 1, 1, 0);
            end
            // offsets at or past VLMAX
            for (int n = 0; n < 2; n++) begin
                run_case($sformatf("big_up_e%0d", 8 << e), SLD_UP, eew, bit'(n), 1, 1);
                run_case($sformatf("big_down_e%0d", 8 << e), SLD_DOWN, eew, bit'(n), 1, 1);
            end
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
